/* Makefile */
SRCS := $(shell grep -v '^+' list.f) common/stats_settings.svh

obj_dir/Vtb_stats: list.f $(SRCS)
	verilator --binary --timing --assert -f list.f --top-module tb_stats -o Vtb_stats

run: obj_dir/Vtb_stats
	./obj_dir/Vtb_stats | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* channel/channel_monitor.sv */
`timescale 1ns/100ps
`include "stats_settings.svh"

// Counts the events of one channel and writes a snapshot of the count
// into that channel's ring of RAM slots as a Wishbone classic master
module channel_monitor #(
  parameter int ChannelId = 0,
  parameter bit Saturate  = 1'b0
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                incr_valid,
  input  stats_pkg::change_t  incr,
  input  logic                decr_valid,
  input  stats_pkg::change_t  decr,
  input  logic                snapshot,
  input  logic                clear,
  output logic                busy,
  output logic                cyc,
  output logic                stb,
  output logic                we,
  output stats_pkg::wb_addr_t adr,
  output stats_pkg::wb_data_t dat_w,
  input  logic                ack
);

  localparam int SlotW = $clog2(`STATS_SLOTS);

  typedef enum logic {
    st_idle,
    st_write
  } state_t;

  state_t            state;
  logic              capture;
  stats_pkg::count_t count;
  logic [SlotW-1:0]  slot;
  logic [7:0]        seq;

  // A snapshot is only taken while no write is pending, the others are dropped
  assign busy    = (state == st_write);
  assign capture = snapshot && !busy;

  // Events keep counting while the write waits for its ack
  // A clear restarts the count from zero plus the changes of the capture cycle
  up_down_counter #(
    .Saturate(Saturate)
  ) u_counter (
    .clk       (clk),
    .arst_n    (arst_n),
    .reinit    (capture && clear),
    .incr_valid(incr_valid),
    .incr      (incr),
    .decr_valid(decr_valid),
    .decr      (decr),
    .value     (count)
  );

  // --------------------
  // Write master
  // --------------------

  // The bus cycle lasts exactly as long as the write is pending
  assign cyc = busy;
  assign we  = busy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
      stb   <= 1'b0;
      slot  <= '0;
      seq   <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (capture) begin
            state <= st_write;
            stb   <= 1'b1;
          end
        end
        st_write: begin
          // The ack cycle still shows cyc and stb, both drop after it
          if (ack) begin
            state <= st_idle;
            stb   <= 1'b0;
            slot  <= slot + 1'b1;
            seq   <= seq + 8'd1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Address and word are frozen at capture and held through the whole cycle
  always_ff @(posedge clk) begin
    if (capture) begin
      adr   <= stats_pkg::wb_addr_t'(ChannelId * `STATS_SLOTS + int'(slot));
      dat_w <= stats_pkg::wb_data_t'({seq, count});
    end
  end

  // --------------------
  // Checks
  // --------------------

  stb_inside_cyc_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    $rose(stb) |-> cyc
  );

  // A dropped snapshot must not disturb the word that is waiting on the bus
  dropped_snapshot_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    snapshot && busy |=> $stable(adr) && $stable(dat_w)
  );

endmodule

/* common/stats_pkg.sv */
`include "stats_settings.svh"

package stats_pkg;

  // --------------------
  // Counter types
  // --------------------

  // One channel count
  typedef logic [`STATS_COUNT_W-1:0] count_t;

  // Wide enough to hold any change from zero up to STATS_MAX_CHANGE
  typedef logic [$clog2(`STATS_MAX_CHANGE + 1)-1:0] change_t;

  // --------------------
  // Bus types
  // --------------------

  // Word address into the statistics RAM
  typedef logic [`STATS_ADDR_W-1:0] wb_addr_t;

  // Snapshot word with the sequence number in the upper byte and the count below
  typedef logic [15:0] wb_data_t;

  // Grant index of the arbiter, which is also the round-robin order
  typedef enum logic [1:0] {
    mst_host = 2'd0,
    mst_ch0  = 2'd1,
    mst_ch1  = 2'd2
  } master_t;

endpackage

/* common/stats_settings.svh */
`ifndef STATS_SETTINGS_SVH
`define STATS_SETTINGS_SVH

// Width of one channel count, which also fills the low byte of a snapshot word
`define STATS_COUNT_W 8

// Largest amount a counter may move up or down in a single cycle
`define STATS_MAX_CHANGE 3

// Snapshot slots per channel, kept as a power of two so the slot index wraps
`define STATS_SLOTS 4

// RAM word address, channel number times STATS_SLOTS plus the slot
`define STATS_ADDR_W 3

`endif

/* hw/stats_ram.sv */
`timescale 1ns/100ps
`include "stats_settings.svh"

// Wishbone classic slave holding the snapshot words of both channels
module stats_ram (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                cyc,
  input  logic                stb,
  input  logic                we,
  input  stats_pkg::wb_addr_t adr,
  input  stats_pkg::wb_data_t dat_w,
  output logic                ack,
  output stats_pkg::wb_data_t dat_r
);

  localparam int Depth = 1 << `STATS_ADDR_W;

  stats_pkg::wb_data_t mem [Depth];
  logic                access;

  // A strobe is served once, the cycle with ack high does not count again
  assign access = cyc && stb && !ack;

  // Slots read back as zero until their first snapshot lands
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack <= 1'b0;
      for (int i = 0; i < Depth; i++) begin
        mem[i] <= '0;
      end
    end else begin
      ack <= access;
      if (access && we) begin
        mem[adr] <= dat_w;
      end
    end
  end

  // Read data comes out together with ack
  always_ff @(posedge clk) begin
    if (access) begin
      dat_r <= mem[adr];
    end
  end

endmodule

/* hw/stats_top.sv */
`timescale 1ns/100ps

// Two channel monitors and a host reader sharing one statistics RAM
module stats_top (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                ch0_incr_valid,
  input  stats_pkg::change_t  ch0_incr,
  input  logic                ch0_decr_valid,
  input  stats_pkg::change_t  ch0_decr,
  input  logic                ch0_snapshot,
  input  logic                ch0_clear,
  output logic                ch0_busy,
  input  logic                ch1_incr_valid,
  input  stats_pkg::change_t  ch1_incr,
  input  logic                ch1_decr_valid,
  input  stats_pkg::change_t  ch1_decr,
  input  logic                ch1_snapshot,
  input  logic                ch1_clear,
  output logic                ch1_busy,
  input  logic                host_cyc,
  input  logic                host_stb,
  input  stats_pkg::wb_addr_t host_adr,
  output logic                host_ack,
  output stats_pkg::wb_data_t host_dat_r
);

  // --------------------
  // Bus wires
  // --------------------

  logic                ch0_cyc;
  logic                ch0_stb;
  logic                ch0_we;
  stats_pkg::wb_addr_t ch0_adr;
  stats_pkg::wb_data_t ch0_dat_w;
  logic                ch0_ack;
  logic                ch1_cyc;
  logic                ch1_stb;
  logic                ch1_we;
  stats_pkg::wb_addr_t ch1_adr;
  stats_pkg::wb_data_t ch1_dat_w;
  logic                ch1_ack;
  logic                s_cyc;
  logic                s_stb;
  logic                s_we;
  stats_pkg::wb_addr_t s_adr;
  stats_pkg::wb_data_t s_dat_w;
  logic                s_ack;
  stats_pkg::wb_data_t s_dat_r;

  // Channel 0 clamps at its bounds
  channel_monitor #(
    .ChannelId(0),
    .Saturate (1'b1)
  ) u_ch0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .incr_valid(ch0_incr_valid),
    .incr      (ch0_incr),
    .decr_valid(ch0_decr_valid),
    .decr      (ch0_decr),
    .snapshot  (ch0_snapshot),
    .clear     (ch0_clear),
    .busy      (ch0_busy),
    .cyc       (ch0_cyc),
    .stb       (ch0_stb),
    .we        (ch0_we),
    .adr       (ch0_adr),
    .dat_w     (ch0_dat_w),
    .ack       (ch0_ack)
  );

  // Channel 1 wraps around
  channel_monitor #(
    .ChannelId(1),
    .Saturate (1'b0)
  ) u_ch1 (
    .clk       (clk),
    .arst_n    (arst_n),
    .incr_valid(ch1_incr_valid),
    .incr      (ch1_incr),
    .decr_valid(ch1_decr_valid),
    .decr      (ch1_decr),
    .snapshot  (ch1_snapshot),
    .clear     (ch1_clear),
    .busy      (ch1_busy),
    .cyc       (ch1_cyc),
    .stb       (ch1_stb),
    .we        (ch1_we),
    .adr       (ch1_adr),
    .dat_w     (ch1_dat_w),
    .ack       (ch1_ack)
  );

  // The host only reads, so its write side is tied off here
  // The monitors never read, their read data stays open
  wb_arbiter u_arbiter (
    .clk       (clk),
    .arst_n    (arst_n),
    .host_cyc  (host_cyc),
    .host_stb  (host_stb),
    .host_we   (1'b0),
    .host_adr  (host_adr),
    .host_dat_w('0),
    .host_ack  (host_ack),
    .host_dat_r(host_dat_r),
    .ch0_cyc   (ch0_cyc),
    .ch0_stb   (ch0_stb),
    .ch0_we    (ch0_we),
    .ch0_adr   (ch0_adr),
    .ch0_dat_w (ch0_dat_w),
    .ch0_ack   (ch0_ack),
    .ch0_dat_r (),
    .ch1_cyc   (ch1_cyc),
    .ch1_stb   (ch1_stb),
    .ch1_we    (ch1_we),
    .ch1_adr   (ch1_adr),
    .ch1_dat_w (ch1_dat_w),
    .ch1_ack   (ch1_ack),
    .ch1_dat_r (),
    .s_cyc     (s_cyc),
    .s_stb     (s_stb),
    .s_we      (s_we),
    .s_adr     (s_adr),
    .s_dat_w   (s_dat_w),
    .s_ack     (s_ack),
    .s_dat_r   (s_dat_r)
  );

  stats_ram u_ram (
    .clk   (clk),
    .arst_n(arst_n),
    .cyc   (s_cyc),
    .stb   (s_stb),
    .we    (s_we),
    .adr   (s_adr),
    .dat_w (s_dat_w),
    .ack   (s_ack),
    .dat_r (s_dat_r)
  );

endmodule

/* hw/up_down_counter.sv */
`timescale 1ns/100ps

// Up/down event counter with a bounded change per cycle
// The result either clamps at the ends of the count range or wraps around it
module up_down_counter #(
  parameter bit Saturate = 1'b0
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               reinit,
  input  logic               incr_valid,
  input  stats_pkg::change_t incr,
  input  logic               decr_valid,
  input  stats_pkg::change_t decr,
  output stats_pkg::count_t  value
);

  localparam int CountW = $bits(stats_pkg::count_t);
  // Two extra bits hold the carry above the top and the sign below zero
  localparam int TempW  = CountW + 2;

  stats_pkg::change_t incr_qual;
  stats_pkg::change_t decr_qual;
  stats_pkg::count_t  base;
  stats_pkg::count_t  value_next;
  logic [TempW-1:0]   value_temp;
  logic               value_loaden;

  // --------------------
  // Next value
  // --------------------

  // A change only counts when its valid is set
  assign incr_qual = incr_valid ? incr : '0;
  assign decr_qual = decr_valid ? decr : '0;

  // On reinit the changes of the same cycle apply to zero instead of the old value
  assign base = reinit ? '0 : value;

  assign value_temp = TempW'(base) + TempW'(incr_qual) - TempW'(decr_qual);

  if (Saturate) begin : gen_saturate
    logic underflow;
    logic overflow;

    // The sign bit is only set when the sum went below zero
    assign underflow  = value_temp[CountW+1];
    // Otherwise a set carry bit means the sum passed the top of the range
    assign overflow   = !underflow && value_temp[CountW];
    assign value_next = underflow ? '0 : (overflow ? '1 : value_temp[CountW-1:0]);
  end else begin : gen_wrap
    // Dropping the upper bits is the modulo of a power of two range
    assign value_next = value_temp[CountW-1:0];
  end

  // --------------------
  // Value register
  // --------------------

  // Idle cycles leave the register alone
  assign value_loaden = reinit || incr_valid || decr_valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      value <= '0;
    end else if (value_loaden) begin
      value <= value_next;
    end
  end

  // --------------------
  // Checks
  // --------------------

  // Without a change or a reinit the count must not move
  value_holds_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    !reinit && !incr_valid && !decr_valid |=> value == $past(value)
  );

  // A bare reinit lands on zero one cycle later
  reinit_zero_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    reinit && !incr_valid && !decr_valid |=> value == '0
  );

endmodule

/* hw/wb_arbiter.sv */
`timescale 1ns/100ps

// Round-robin arbiter that lets three Wishbone classic masters share one slave
module wb_arbiter (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                host_cyc,
  input  logic                host_stb,
  input  logic                host_we,
  input  stats_pkg::wb_addr_t host_adr,
  input  stats_pkg::wb_data_t host_dat_w,
  output logic                host_ack,
  output stats_pkg::wb_data_t host_dat_r,
  input  logic                ch0_cyc,
  input  logic                ch0_stb,
  input  logic                ch0_we,
  input  stats_pkg::wb_addr_t ch0_adr,
  input  stats_pkg::wb_data_t ch0_dat_w,
  output logic                ch0_ack,
  output stats_pkg::wb_data_t ch0_dat_r,
  input  logic                ch1_cyc,
  input  logic                ch1_stb,
  input  logic                ch1_we,
  input  stats_pkg::wb_addr_t ch1_adr,
  input  stats_pkg::wb_data_t ch1_dat_w,
  output logic                ch1_ack,
  output stats_pkg::wb_data_t ch1_dat_r,
  output logic                s_cyc,
  output logic                s_stb,
  output logic                s_we,
  output stats_pkg::wb_addr_t s_adr,
  output stats_pkg::wb_data_t s_dat_w,
  input  logic                s_ack,
  input  stats_pkg::wb_data_t s_dat_r
);

  localparam int NumMasters = 3;

  logic [NumMasters-1:0] req;
  stats_pkg::master_t    grant;
  stats_pkg::master_t    last;
  stats_pkg::master_t    pick;
  logic                  pick_valid;
  logic                  owner_valid;
  logic                  grant_cyc;
  logic                  grant_stb;

  // Bit positions follow the encoding of master_t
  assign req = {ch1_cyc, ch0_cyc, host_cyc};

  // --------------------
  // Round-robin pick
  // --------------------

  // Walks backwards so the first requester after the last served one wins
  always_comb begin
    int idx;
    pick       = last;
    pick_valid = 1'b0;
    for (int i = NumMasters; i >= 1; i--) begin
      idx = (int'(last) + i) % NumMasters;
      if (req[idx]) begin
        pick       = stats_pkg::master_t'(idx[1:0]);
        pick_valid = 1'b1;
      end
    end
  end

  // Grants only on an idle bus and releases once the owner drops cyc
  // Reset leaves ch1 as the last served so the host comes first
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      owner_valid <= 1'b0;
      grant       <= stats_pkg::mst_host;
      last        <= stats_pkg::mst_ch1;
    end else if (!owner_valid) begin
      if (pick_valid) begin
        grant       <= pick;
        owner_valid <= 1'b1;
      end
    end else if (!grant_cyc) begin
      owner_valid <= 1'b0;
      last        <= grant;
    end
  end

  // --------------------
  // Request and response paths
  // --------------------

  always_comb begin
    case (grant)
      stats_pkg::mst_host: begin
        grant_cyc = host_cyc;
        grant_stb = host_stb;
        s_we      = host_we;
        s_adr     = host_adr;
        s_dat_w   = host_dat_w;
      end
      stats_pkg::mst_ch0: begin
        grant_cyc = ch0_cyc;
        grant_stb = ch0_stb;
        s_we      = ch0_we;
        s_adr     = ch0_adr;
        s_dat_w   = ch0_dat_w;
      end
      default: begin
        grant_cyc = ch1_cyc;
        grant_stb = ch1_stb;
        s_we      = ch1_we;
        s_adr     = ch1_adr;
        s_dat_w   = ch1_dat_w;
      end
    endcase
  end

  // The slave sees nothing until a grant is in place
  assign s_cyc = owner_valid && grant_cyc;
  assign s_stb = owner_valid && grant_stb;

  // Only the owner gets the ack, read data is shared and qualified by it
  assign host_ack   = owner_valid && (grant == stats_pkg::mst_host) && s_ack;
  assign ch0_ack    = owner_valid && (grant == stats_pkg::mst_ch0) && s_ack;
  assign ch1_ack    = owner_valid && (grant == stats_pkg::mst_ch1) && s_ack;
  assign host_dat_r = s_dat_r;
  assign ch0_dat_r  = s_dat_r;
  assign ch1_dat_r  = s_dat_r;

  // An open bus cycle keeps its owner
  grant_stable_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    owner_valid && grant_cyc |=> grant == $past(grant)
  );

endmodule

/* list.f */
+incdir+common
common/stats_pkg.sv
hw/up_down_counter.sv
channel/channel_monitor.sv
hw/wb_arbiter.sv
hw/stats_ram.sv
hw/stats_top.sv
tests/tb_clock.sv
tests/tb_stats.sv

/* tests/tb_clock.sv */
`timescale 1ns/100ps

// Free running 10 ns clock with a reset that is held low for the first five cycles
module tb_clock (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Release away from the rising edge so no flop sees reset and clock together
  initial begin
    arst_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

/* tests/tb_stats.sv */
`timescale 1ns/100ps
`include "stats_settings.svh"

// Directed testbench for the statistics block
// A model of both channels predicts every snapshot word and the RAM contents
module tb_stats;

  localparam int QuietLimit = 60;
  localparam int RamDepth   = 1 << `STATS_ADDR_W;
  localparam int CountMax   = (1 << `STATS_COUNT_W) - 1;

  logic                clk;
  logic                arst_n;
  logic                ch0_incr_valid;
  stats_pkg::change_t  ch0_incr;
  logic                ch0_decr_valid;
  stats_pkg::change_t  ch0_decr;
  logic                ch0_snapshot;
  logic                ch0_clear;
  logic                ch0_busy;
  logic                ch1_incr_valid;
  stats_pkg::change_t  ch1_incr;
  logic                ch1_decr_valid;
  stats_pkg::change_t  ch1_decr;
  logic                ch1_snapshot;
  logic                ch1_clear;
  logic                ch1_busy;
  logic                host_cyc;
  logic                host_stb;
  stats_pkg::wb_addr_t host_adr;
  logic                host_ack;
  stats_pkg::wb_data_t host_dat_r;

  // Inputs staged for the next rising edge, bit or entry c belongs to channel c
  logic [1:0]          nx_iv;
  logic [1:0]          nx_dv;
  logic [1:0]          nx_snap;
  logic [1:0]          nx_clr;
  stats_pkg::change_t  nx_inc [2];
  stats_pkg::change_t  nx_dec [2];
  logic                nx_host_cyc;
  stats_pkg::wb_addr_t nx_host_adr;

  // --------------------
  // Reference model
  // --------------------

  stats_pkg::count_t   m_count [2];
  int                  m_slot [2];
  logic [7:0]          m_seq [2];
  logic [1:0]          m_busy;
  // Set once busy was seen high, so the launch cycle is not taken for the end
  logic [1:0]          m_seen;
  stats_pkg::wb_data_t m_word [2];
  stats_pkg::wb_addr_t m_adr [2];
  stats_pkg::wb_data_t m_ram [RamDepth];

  logic                host_pending;
  stats_pkg::wb_data_t host_data;
  logic [15:0]         lfsr;
  logic [1:0]          busy_now;

  assign busy_now = {ch1_busy, ch0_busy};

  tb_clock u_clock (
    .clk   (clk),
    .arst_n(arst_n)
  );

  stats_top dut (
    .clk           (clk),
    .arst_n        (arst_n),
    .ch0_incr_valid(ch0_incr_valid),
    .ch0_incr      (ch0_incr),
    .ch0_decr_valid(ch0_decr_valid),
    .ch0_decr      (ch0_decr),
    .ch0_snapshot  (ch0_snapshot),
    .ch0_clear     (ch0_clear),
    .ch0_busy      (ch0_busy),
    .ch1_incr_valid(ch1_incr_valid),
    .ch1_incr      (ch1_incr),
    .ch1_decr_valid(ch1_decr_valid),
    .ch1_decr      (ch1_decr),
    .ch1_snapshot  (ch1_snapshot),
    .ch1_clear     (ch1_clear),
    .ch1_busy      (ch1_busy),
    .host_cyc      (host_cyc),
    .host_stb      (host_stb),
    .host_adr      (host_adr),
    .host_ack      (host_ack),
    .host_dat_r    (host_dat_r)
  );

  // Galois LFSR, one step for every random bit handed out
  function automatic logic next_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
    return b;
  endfunction

  function automatic stats_pkg::change_t rand_change();
    logic b1;
    logic b0;
    b1 = next_bit();
    b0 = next_bit();
    return {b1, b0};
  endfunction

  // Channel 0 clamps to the count range, channel 1 wraps modulo its size
  function automatic stats_pkg::count_t apply_change(input int ch,
                                                     input stats_pkg::count_t base,
                                                     input stats_pkg::change_t inc,
                                                     input stats_pkg::change_t dec);
    int sum;
    sum = int'(base) + int'(inc) - int'(dec);
    if (ch == 0 && sum < 0) begin
      sum = 0;
    end
    if (ch == 0 && sum > CountMax) begin
      sum = CountMax;
    end
    return stats_pkg::count_t'(sum);
  endfunction

  // --------------------
  // Checks
  // --------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_count(input string name, input stats_pkg::count_t got,
                             input stats_pkg::count_t exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input stats_pkg::wb_data_t got,
                            input stats_pkg::wb_data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  // --------------------
  // Clocking of stimulus and model
  // --------------------

  // Drives the staged inputs on one rising edge, advances the model, returns at the
  // falling edge where the outputs are settled
  task automatic tick();
    stats_pkg::count_t  base;
    stats_pkg::change_t inc;
    stats_pkg::change_t dec;
    @(posedge clk);
    ch0_incr_valid <= nx_iv[0];
    ch0_incr       <= nx_inc[0];
    ch0_decr_valid <= nx_dv[0];
    ch0_decr       <= nx_dec[0];
    ch0_snapshot   <= nx_snap[0];
    ch0_clear      <= nx_clr[0];
    ch1_incr_valid <= nx_iv[1];
    ch1_incr       <= nx_inc[1];
    ch1_decr_valid <= nx_dv[1];
    ch1_decr       <= nx_dec[1];
    ch1_snapshot   <= nx_snap[1];
    ch1_clear      <= nx_clr[1];
    host_cyc       <= nx_host_cyc;
    host_stb       <= nx_host_cyc;
    host_adr       <= nx_host_adr;
    for (int c = 0; c < 2; c++) begin
      base = m_count[c];
      // The word holds the count from before this cycle's changes
      if (nx_snap[c] && !m_busy[c]) begin
        m_word[c] = {m_seq[c], m_count[c]};
        m_adr[c]  = stats_pkg::wb_addr_t'(c * `STATS_SLOTS + m_slot[c]);
        m_busy[c] = 1'b1;
        m_seen[c] = 1'b0;
        if (nx_clr[c]) begin
          base = '0;
        end
      end
      inc        = nx_iv[c] ? nx_inc[c] : '0;
      dec        = nx_dv[c] ? nx_dec[c] : '0;
      m_count[c] = apply_change(c, base, inc, dec);
      nx_inc[c]  = '0;
      nx_dec[c]  = '0;
    end
    nx_iv   = '0;
    nx_dv   = '0;
    nx_snap = '0;
    nx_clr  = '0;
    @(negedge clk);
  endtask

  // Clocks until the host read and both channel writes are done
  task automatic run_until_quiet();
    int n;
    n = 0;
    do begin
      tick();
      n++;
      if (host_pending && host_ack) begin
        host_data    = host_dat_r;
        host_pending = 1'b0;
        nx_host_cyc  = 1'b0;
      end
      for (int c = 0; c < 2; c++) begin
        // Busy may only be high while the model has a write pending
        if (busy_now[c] && !m_busy[c]) begin
          abort_run($sformatf("** Error at %0t: ch%0d_busy is %b, expected %b",
                              $time, c, busy_now[c], 1'b0));
        end
        if (m_busy[c] && busy_now[c]) begin
          m_seen[c] = 1'b1;
        end else if (m_busy[c] && m_seen[c]) begin
          // Write finished, so the slot and sequence number move on
          m_busy[c]        = 1'b0;
          m_ram[m_adr[c]]  = m_word[c];
          m_slot[c]        = (m_slot[c] + 1) % `STATS_SLOTS;
          m_seq[c]         = m_seq[c] + 8'd1;
        end
      end
      if (n > QuietLimit) begin
        abort_run("Timeout: a bus access never got its ack or busy stayed high");
      end
    end while (host_pending || host_cyc || m_busy != 2'b00);
  endtask

  task automatic host_read(input stats_pkg::wb_addr_t adr, output stats_pkg::wb_data_t data);
    nx_host_cyc  = 1'b1;
    nx_host_adr  = adr;
    host_pending = 1'b1;
    run_until_quiet();
    data = host_data;
  endtask

  task automatic read_and_check(input stats_pkg::wb_addr_t adr, input string name);
    stats_pkg::wb_data_t data;
    host_read(adr, data);
    check_word(name, data, m_ram[adr]);
  endtask

  // both forces incr and decr valid in every cycle
  task automatic drive_random(input int n, input bit both);
    for (int k = 0; k < n; k++) begin
      for (int c = 0; c < 2; c++) begin
        nx_iv[c]  = both ? 1'b1 : next_bit();
        nx_inc[c] = rand_change();
        nx_dv[c]  = both ? 1'b1 : next_bit();
        nx_dec[c] = rand_change();
      end
      tick();
    end
  endtask

  // --------------------
  // Directed tests
  // --------------------

  // Five snapshots go round the four slots of channel 0
  task automatic test_slot_ring();
    for (int k = 0; k < 5; k++) begin
      drive_random(3, 1'b0);
      nx_snap = 2'b01;
      run_until_quiet();
    end
    for (int a = 0; a < `STATS_SLOTS; a++) begin
      read_and_check(stats_pkg::wb_addr_t'(a), "slot ring word");
    end
  endtask

  task automatic test_counting();
    stats_pkg::wb_data_t data;
    drive_random(20, 1'b1);
    nx_snap = 2'b11;
    run_until_quiet();
    host_read(m_adr[0], data);
    check_count("ch0 count byte", data[7:0], m_ram[m_adr[0]][7:0]);
    host_read(m_adr[1], data);
    check_count("ch1 count byte", data[7:0], m_ram[m_adr[1]][7:0]);
  endtask

  // up pushes both channels past the top, otherwise below zero
  task automatic push_and_check(input bit up);
    stats_pkg::wb_data_t data;
    for (int k = 0; k < 100; k++) begin
      nx_iv     = up ? 2'b11 : 2'b00;
      nx_dv     = up ? 2'b00 : 2'b11;
      nx_inc[0] = 2'd3;
      nx_inc[1] = 2'd3;
      nx_dec[0] = 2'd3;
      nx_dec[1] = 2'd3;
      tick();
    end
    nx_snap = 2'b11;
    run_until_quiet();
    host_read(m_adr[0], data);
    check_word("ch0 bound word", data, m_ram[m_adr[0]]);
    check_count("ch0 clamped count", data[7:0], up ? '1 : '0);
    read_and_check(m_adr[1], "ch1 wrapped word");
  endtask

  task automatic test_clear();
    stats_pkg::wb_data_t data;
    drive_random(5, 1'b0);
    // Clear together with +3 and -1, so the new count starts at 2
    nx_snap   = 2'b01;
    nx_clr    = 2'b01;
    nx_iv     = 2'b01;
    nx_inc[0] = 2'd3;
    nx_dv     = 2'b01;
    nx_dec[0] = 2'd1;
    run_until_quiet();
    read_and_check(m_adr[0], "word before clear");
    for (int k = 0; k < 4; k++) begin
      nx_iv     = 2'b01;
      nx_inc[0] = 2'd2;
      tick();
    end
    nx_snap = 2'b01;
    run_until_quiet();
    host_read(m_adr[0], data);
    check_word("word after clear", data, m_ram[m_adr[0]]);
    check_count("count after clear", data[7:0], 8'd10);
  endtask

  // Both channels and the host start in the same cycle
  task automatic test_contention();
    stats_pkg::wb_addr_t adr;
    adr          = stats_pkg::wb_addr_t'((m_slot[0] + 1) % `STATS_SLOTS);
    nx_snap      = 2'b11;
    nx_host_cyc  = 1'b1;
    nx_host_adr  = adr;
    host_pending = 1'b1;
    run_until_quiet();
    check_word("host read under contention", host_data, m_ram[adr]);
    read_and_check(m_adr[0], "ch0 contention word");
    read_and_check(m_adr[1], "ch1 contention word");
  endtask

  task automatic test_dropped();
    drive_random(2, 1'b0);
    nx_snap = 2'b10;
    tick();
    // Second pulse is sampled while the first write is pending
    nx_snap = 2'b10;
    tick();
    if (!ch1_busy) begin
      abort_run($sformatf("** Error at %0t: ch1_busy is %b, expected %b",
                          $time, ch1_busy, 1'b1));
    end
    run_until_quiet();
    read_and_check(m_adr[1], "ch1 word before dropped pulse");
    read_and_check(stats_pkg::wb_addr_t'(`STATS_SLOTS + m_slot[1]), "ch1 untouched slot");
    // The next snapshot must take the very next slot and sequence number
    nx_snap = 2'b10;
    run_until_quiet();
    read_and_check(m_adr[1], "ch1 word after dropped pulse");
  endtask

  initial begin
    ch0_incr_valid <= 1'b0;
    ch0_incr       <= '0;
    ch0_decr_valid <= 1'b0;
    ch0_decr       <= '0;
    ch0_snapshot   <= 1'b0;
    ch0_clear      <= 1'b0;
    ch1_incr_valid <= 1'b0;
    ch1_incr       <= '0;
    ch1_decr_valid <= 1'b0;
    ch1_decr       <= '0;
    ch1_snapshot   <= 1'b0;
    ch1_clear      <= 1'b0;
    host_cyc       <= 1'b0;
    host_stb       <= 1'b0;
    host_adr       <= '0;
    nx_iv          = '0;
    nx_dv          = '0;
    nx_snap        = '0;
    nx_clr         = '0;
    nx_host_cyc    = 1'b0;
    nx_host_adr    = '0;
    host_pending   = 1'b0;
    host_data      = '0;
    m_busy         = '0;
    m_seen         = '0;
    lfsr           = 16'd42;
    for (int c = 0; c < 2; c++) begin
      nx_inc[c]  = '0;
      nx_dec[c]  = '0;
      m_count[c] = '0;
      m_slot[c]  = 0;
      m_seq[c]   = '0;
      m_word[c]  = '0;
      m_adr[c]   = '0;
    end
    // The RAM comes out of reset all zero
    for (int a = 0; a < RamDepth; a++) begin
      m_ram[a] = '0;
    end
    for (int i = 0; i < 20 && arst_n !== 1'b1; i++) begin
      @(negedge clk);
    end
    if (arst_n !== 1'b1) begin
      abort_run("Reset was never released");
    end
    test_slot_ring();
    test_counting();
    push_and_check(1'b1);
    push_and_check(1'b0);
    test_clear();
    test_contention();
    test_dropped();
    $display("sim passed");
    $finish;
  end

endmodule
